// ==== regress_pkg.sv ====
package regress_pkg;

    // --------------------
    // fixed point format
    // --------------------
    localparam int FX_WIDTH = 32;  // Q16.16 word
    localparam int FX_FRAC  = 16;  // fraction bits

    // --------------------
    // arithmetic unit latencies
    // --------------------
    localparam int MUL_LAT = 2;
    localparam int DIV_LAT = 4;

    // back substitution: beta2 div, then mul+div for beta1 and for beta0
    localparam int BSUB_LAT = DIV_LAT + 2 * (MUL_LAT + DIV_LAT);

    // input capture to output register, every stage counted
    localparam int SOLVE_LATENCY = 1              // capture
                                 + 1              // pivot column 0
                                 + DIV_LAT + 1    // normalise row 0
                                 + MUL_LAT + 1    // eliminate column 0
                                 + 1              // pivot column 1
                                 + DIV_LAT + 1    // normalise row 1
                                 + MUL_LAT + 1    // eliminate column 1
                                 + DIV_LAT + 1    // normalise row 2
                                 + BSUB_LAT       // beta2, beta1, beta0
                                 + 1;             // output register

    typedef logic signed [FX_WIDTH-1:0] fx_t;

    // [0..2] coefficients, [3] right-hand side
    typedef fx_t [3:0] fx_row_t;

    typedef struct packed {
        fx_t [8:0] a_coef;  // row-major, a_coef[r*3+c]
        fx_t [2:0] b_rhs;
    } solve_req_t;

    typedef struct packed {
        fx_t [2:0] beta;    // all zero when singular
        logic      singular;
    } solve_rsp_t;

endpackage

// ==== fx_mul.sv ====
`timescale 1ns/1ns

module fx_mul #(
    parameter int LATENCY = regress_pkg::MUL_LAT
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  regress_pkg::fx_t a,
    input  regress_pkg::fx_t b,
    output logic             valid_out,
    output regress_pkg::fx_t result
);

    logic signed [2*regress_pkg::FX_WIDTH-1:0] prod_full;  // Q32.32 product
    regress_pkg::fx_t prod_pipe [LATENCY];
    logic [LATENCY-1:0] vld_pipe;

    always_comb begin
        prod_full = a * b;                           // signed, extended to 64 bits
        prod_full = prod_full >>> regress_pkg::FX_FRAC;  // back to Q16.16, floor
    end

    // valid chain, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= valid_in;
            for (int i = 1; i < LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        prod_pipe[0] <= prod_full[regress_pkg::FX_WIDTH-1:0];  // truncate to one word
        for (int i = 1; i < LATENCY; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    assign valid_out = vld_pipe[LATENCY-1];
    assign result    = prod_pipe[LATENCY-1];

endmodule

// ==== fx_div.sv ====
`timescale 1ns/1ns

module fx_div #(
    parameter int LATENCY = regress_pkg::DIV_LAT
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  regress_pkg::fx_t numerator,
    input  regress_pkg::fx_t denominator,
    output logic             valid_out,
    output regress_pkg::fx_t result
);

    logic signed [2*regress_pkg::FX_WIDTH-1:0] num_ext;   // numerator in Q32.32
    logic signed [2*regress_pkg::FX_WIDTH-1:0] den_ext;
    logic signed [2*regress_pkg::FX_WIDTH-1:0] quo_full;
    regress_pkg::fx_t quo_pipe [LATENCY];
    logic [LATENCY-1:0] vld_pipe;

    // --------------------
    // combinational divide
    // --------------------
    always_comb begin
        num_ext = {{regress_pkg::FX_WIDTH{numerator[regress_pkg::FX_WIDTH-1]}}, numerator};
        num_ext = num_ext <<< regress_pkg::FX_FRAC;  // pre-scale so quotient stays Q16.16
        den_ext = {{regress_pkg::FX_WIDTH{denominator[regress_pkg::FX_WIDTH-1]}}, denominator};
        if (denominator == '0) begin
            quo_full = '0;                // zero pivot, flagged upstream
        end else begin
            quo_full = num_ext / den_ext; // signed, truncates toward zero
        end
    end

    // --------------------
    // latency chain
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= valid_in;
            for (int i = 1; i < LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        quo_pipe[0] <= quo_full[regress_pkg::FX_WIDTH-1:0];
        for (int i = 1; i < LATENCY; i++) begin
            quo_pipe[i] <= quo_pipe[i-1];
        end
    end

    assign valid_out = vld_pipe[LATENCY-1];
    assign result    = quo_pipe[LATENCY-1];

endmodule

// ==== gauss_solver3x3.sv ====
`timescale 1ns/1ns

module gauss_solver3x3 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  regress_pkg::fx_t [8:0]  a_coef,
    input  regress_pkg::fx_t [2:0]  b_rhs,
    output logic                    valid_out,
    output regress_pkg::solve_rsp_t result
);

    // matrix of one problem plus its sticky singular flag
    typedef struct packed {
        logic                       sing;
        regress_pkg::fx_row_t [2:0] m;
    } stage_t;

    // back substitution carries the upper triangle and partial results
    typedef struct packed {
        logic                       sing;
        regress_pkg::fx_row_t [2:0] m;
        regress_pkg::fx_t           b2;
        regress_pkg::fx_t           b1;
        regress_pkg::fx_t           p02;  // m[0][2]*beta2
    } bsub_t;

    function automatic logic [regress_pkg::FX_WIDTH-1:0] fx_mag(input regress_pkg::fx_t x);
        fx_mag = x[regress_pkg::FX_WIDTH-1] ? -x : x;  // unsigned view keeps -2^31 right
    endfunction

    stage_t st0, st1, st2, st3, st4, st5, st6, st7;  // stage registers
    logic   v0, v1, v2, v3, v4, v5, v6, v7;          // stage valids
    stage_t sw0, sw1;                                // pivot swaps, comb
    logic [1:0] p0, p1;                              // pivot row indices

    stage_t dl_n0 [regress_pkg::DIV_LAT];  // rows beside the row 0 divides
    stage_t dl_e0 [regress_pkg::MUL_LAT];
    stage_t dl_n1 [regress_pkg::DIV_LAT];
    stage_t dl_e1 [regress_pkg::MUL_LAT];
    stage_t dl_n2 [regress_pkg::DIV_LAT];
    bsub_t  bs    [regress_pkg::BSUB_LAT];

    regress_pkg::fx_t q0 [4];          // normalised row 0
    regress_pkg::fx_t pe0 [1:2][4];    // column 0 elimination products
    regress_pkg::fx_t q1 [1:3];
    regress_pkg::fx_t pe1 [1:3];
    regress_pkg::fx_t q2 [1:3];
    logic [3:0] dv0;
    logic [7:0] mv0;
    logic [3:1] dv1, mv1, dv2;

    regress_pkg::fx_t b2_q, b1_q, b0_q, p12, p02, p01;
    regress_pkg::fx_t num_b1, num_b0;
    logic vb2, vm12, vm02, vb1, vm01, vb0;

    // --------------------
    // pivot selection
    // --------------------
    always_comb begin
        p0 = 2'd0;  // ties keep the upper row
        if (fx_mag(st0.m[1][0]) > fx_mag(st0.m[0][0])) p0 = 2'd1;
        if (fx_mag(st0.m[2][0]) > fx_mag(st0.m[p0][0])) p0 = 2'd2;
        sw0       = st0;
        sw0.m[0]  = st0.m[p0];
        sw0.m[p0] = st0.m[0];
        sw0.sing  = st0.sing | (st0.m[p0][0] == '0);  // whole column zero
    end

    always_comb begin
        p1 = 2'd1;  // only rows 1 and 2 compete
        if (fx_mag(st3.m[2][1]) > fx_mag(st3.m[1][1])) p1 = 2'd2;
        sw1       = st3;
        sw1.m[1]  = st3.m[p1];
        sw1.m[p1] = st3.m[1];
        sw1.sing  = st3.sing | (st3.m[p1][1] == '0);
    end

    // --------------------
    // arithmetic units
    // --------------------
    for (genvar c = 0; c < 4; c++) begin : g_row0
        fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div (
            .clk(clk), .rst_n(rst_n), .valid_in(v1),
            .numerator(st1.m[0][c]), .denominator(st1.m[0][0]),
            .valid_out(dv0[c]), .result(q0[c]));
        for (genvar r = 1; r < 3; r++) begin : g_elim0
            fx_mul #(.LATENCY(regress_pkg::MUL_LAT)) u_mul (
                .clk(clk), .rst_n(rst_n), .valid_in(v2),
                .a(st2.m[r][0]), .b(st2.m[0][c]),
                .valid_out(mv0[(r-1)*4+c]), .result(pe0[r][c]));
        end
    end

    // col 0 of rows 1 and 2 is exactly zero from here on, so only cols 1..3
    for (genvar c = 1; c < 4; c++) begin : g_rows12
        fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div1 (
            .clk(clk), .rst_n(rst_n), .valid_in(v4),
            .numerator(st4.m[1][c]), .denominator(st4.m[1][1]),
            .valid_out(dv1[c]), .result(q1[c]));
        fx_mul #(.LATENCY(regress_pkg::MUL_LAT)) u_mul1 (
            .clk(clk), .rst_n(rst_n), .valid_in(v5),
            .a(st5.m[2][1]), .b(st5.m[1][c]),
            .valid_out(mv1[c]), .result(pe1[c]));
        fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div2 (
            .clk(clk), .rst_n(rst_n), .valid_in(v6),
            .numerator(st6.m[2][c]), .denominator(st6.m[2][2]),
            .valid_out(dv2[c]), .result(q2[c]));
    end

    // --------------------
    // stage registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {v0, v1, v2, v3, v4, v5, v6, v7} <= '0;
        end else begin
            v0 <= valid_in;
            v1 <= v0;
            v2 <= &dv0;
            v3 <= &mv0;
            v4 <= v3;
            v5 <= &dv1;
            v6 <= &mv1;
            v7 <= &dv2;
        end
    end

    always_ff @(posedge clk) begin
        st0.sing <= 1'b0;  // fresh problem
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                st0.m[r][c] <= a_coef[r*3+c];
            end
            st0.m[r][3] <= b_rhs[r];
        end
        st1 <= sw0;
        st2 <= dl_n0[regress_pkg::DIV_LAT-1];
        st3 <= dl_e0[regress_pkg::MUL_LAT-1];
        st4 <= sw1;
        st5 <= dl_n1[regress_pkg::DIV_LAT-1];
        st6 <= dl_e1[regress_pkg::MUL_LAT-1];
        st7 <= dl_n2[regress_pkg::DIV_LAT-1];
        // computed rows override the delayed copies
        for (int c = 0; c < 4; c++) begin
            st2.m[0][c] <= q0[c];
            for (int r = 1; r < 3; r++) begin
                st3.m[r][c] <= dl_e0[regress_pkg::MUL_LAT-1].m[r][c] - pe0[r][c];
            end
        end
        for (int c = 1; c < 4; c++) begin
            st5.m[1][c] <= q1[c];
            st6.m[2][c] <= dl_e1[regress_pkg::MUL_LAT-1].m[2][c] - pe1[c];
            st7.m[2][c] <= q2[c];
        end
        st7.sing <= dl_n2[regress_pkg::DIV_LAT-1].sing
                  | (dl_n2[regress_pkg::DIV_LAT-1].m[2][2] == '0);  // last pivot
    end

    // delay lines matching each unit latency
    always_ff @(posedge clk) begin
        dl_n0[0] <= st1;
        dl_e0[0] <= st2;
        dl_n1[0] <= st4;
        dl_e1[0] <= st5;
        dl_n2[0] <= st6;
        for (int i = 1; i < regress_pkg::DIV_LAT; i++) begin
            dl_n0[i] <= dl_n0[i-1];
            dl_n1[i] <= dl_n1[i-1];
            dl_n2[i] <= dl_n2[i-1];
        end
        for (int i = 1; i < regress_pkg::MUL_LAT; i++) begin
            dl_e0[i] <= dl_e0[i-1];
            dl_e1[i] <= dl_e1[i-1];
        end
    end

    // --------------------
    // back substitution
    // --------------------
    fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div_b2 (
        .clk(clk), .rst_n(rst_n), .valid_in(v7),
        .numerator(st7.m[2][3]), .denominator(st7.m[2][2]),
        .valid_out(vb2), .result(b2_q));

    // both products of beta2 at once, p02 waits in the chain for beta0
    fx_mul #(.LATENCY(regress_pkg::MUL_LAT)) u_mul_b12 (
        .clk(clk), .rst_n(rst_n), .valid_in(vb2),
        .a(bs[regress_pkg::DIV_LAT-1].m[1][2]), .b(b2_q),
        .valid_out(vm12), .result(p12));
    fx_mul #(.LATENCY(regress_pkg::MUL_LAT)) u_mul_b02 (
        .clk(clk), .rst_n(rst_n), .valid_in(vb2),
        .a(bs[regress_pkg::DIV_LAT-1].m[0][2]), .b(b2_q),
        .valid_out(vm02), .result(p02));

    assign num_b1 = bs[regress_pkg::DIV_LAT+regress_pkg::MUL_LAT-1].m[1][3] - p12;

    fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div_b1 (
        .clk(clk), .rst_n(rst_n), .valid_in(vm12 & vm02),
        .numerator(num_b1),
        .denominator(bs[regress_pkg::DIV_LAT+regress_pkg::MUL_LAT-1].m[1][1]),
        .valid_out(vb1), .result(b1_q));

    fx_mul #(.LATENCY(regress_pkg::MUL_LAT)) u_mul_b01 (
        .clk(clk), .rst_n(rst_n), .valid_in(vb1),
        .a(bs[2*regress_pkg::DIV_LAT+regress_pkg::MUL_LAT-1].m[0][1]), .b(b1_q),
        .valid_out(vm01), .result(p01));

    assign num_b0 = bs[2*regress_pkg::DIV_LAT+2*regress_pkg::MUL_LAT-1].m[0][3]
                  - bs[2*regress_pkg::DIV_LAT+2*regress_pkg::MUL_LAT-1].p02 - p01;

    fx_div #(.LATENCY(regress_pkg::DIV_LAT)) u_div_b0 (
        .clk(clk), .rst_n(rst_n), .valid_in(vm01),
        .numerator(num_b0),
        .denominator(bs[2*regress_pkg::DIV_LAT+2*regress_pkg::MUL_LAT-1].m[0][0]),
        .valid_out(vb0), .result(b0_q));

    // chain of the upper triangle, partial results dropped in as they appear
    always_ff @(posedge clk) begin
        bs[0]      <= '0;
        bs[0].sing <= st7.sing;
        bs[0].m    <= st7.m;
        for (int i = 1; i < regress_pkg::BSUB_LAT; i++) begin
            bs[i] <= bs[i-1];
        end
        bs[regress_pkg::DIV_LAT].b2                       <= b2_q;
        bs[regress_pkg::DIV_LAT+regress_pkg::MUL_LAT].p02 <= p02;
        bs[2*regress_pkg::DIV_LAT+regress_pkg::MUL_LAT].b1 <= b1_q;
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= vb0;
        end
    end

    always_ff @(posedge clk) begin
        result.singular <= bs[regress_pkg::BSUB_LAT-1].sing;
        if (bs[regress_pkg::BSUB_LAT-1].sing) begin
            result.beta <= '0;  // no solution reported
        end else begin
            result.beta[2] <= bs[regress_pkg::BSUB_LAT-1].b2;
            result.beta[1] <= bs[regress_pkg::BSUB_LAT-1].b1;
            result.beta[0] <= b0_q;
        end
    end

endmodule

// ==== regress_top.sv ====
`timescale 1ns/1ns

module regress_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,  // no ready, one problem per high cycle
    input  regress_pkg::solve_req_t req,
    output logic                    rsp_valid,  // one pulse per accepted problem
    output regress_pkg::solve_rsp_t rsp
);

    // stream goes straight into the solver pipeline
    gauss_solver3x3 u_solver (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req_valid),
        .a_coef    (req.a_coef),
        .b_rhs     (req.b_rhs),
        .valid_out (rsp_valid),
        .result    (rsp)
    );

endmodule

// ==== regress_assert.sv ====
`timescale 1ns/1ns

module regress_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    valid_in,
    input logic                    valid_out,
    input regress_pkg::solve_rsp_t result
);

    int unsigned fail_cnt = 0;  // failed assertion count

    // --------------------
    // stream timing
    // --------------------
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_out)
        else begin
            $error("valid_out high during reset");
            fail_cnt++;
        end

    // one output pulse per input pulse, fixed pipeline depth
    fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in, regress_pkg::SOLVE_LATENCY))
        else begin
            $error("valid_out does not follow valid_in by the pipeline latency");
            fail_cnt++;
        end

    // --------------------
    // singular results
    // --------------------
    zero_beta: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && result.singular) |-> (result.beta == '0))
        else begin
            $error("singular result carries a nonzero beta");
            fail_cnt++;
        end

endmodule

bind gauss_solver3x3 regress_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .result    (result)
);

// ==== tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // reset held low for the first 5 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;  // release lands just after the edge
    end

endmodule

// ==== tb_regress.sv ====
`timescale 1ns/1ns

module tb_regress;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    regress_pkg::solve_req_t req;
    logic                    rsp_valid;
    regress_pkg::solve_rsp_t rsp;

    logic [31:0]             vec_mem [0:1023];  // count word, then 16 words per problem
    regress_pkg::solve_req_t vec_req [$];
    regress_pkg::solve_rsp_t vec_exp [$];
    regress_pkg::solve_rsp_t exp_q [$];         // expectations in send order
    string                   name_q [$];
    int num_vec  = 0;
    int sent_cnt = 0;
    int recv_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int misc_err = 0;  // stray or missing responses, bad vector file

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    regress_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // reset, two lone problems, gapped pass, back-to-back pass, drain, margin
    function automatic int run_cycles(input int n_vec);
        int lat;
        lat = regress_pkg::SOLVE_LATENCY;
        return 10 + 2 * (lat + 4) + 5 * n_vec + 2 + lat + 15 + 20;
    endfunction

    task automatic load_vectors();
        int base;
        regress_pkg::solve_req_t r;
        regress_pkg::solve_rsp_t e;
        $readmemh("regress_vectors.txt", vec_mem);
        num_vec = int'(vec_mem[0]);
        if (num_vec < 1 || num_vec * 16 + 1 > $size(vec_mem)) begin
            num_vec = 0;
        end
        for (int n = 0; n < num_vec; n++) begin
            base = 1 + n * 16;
            for (int k = 0; k < 9; k++) begin
                r.a_coef[k] = vec_mem[base + k];  // row-major A
            end
            for (int k = 0; k < 3; k++) begin
                r.b_rhs[k] = vec_mem[base + 9 + k];
                e.beta[k]  = vec_mem[base + 12 + k];
            end
            e.singular = vec_mem[base + 15][0];
            vec_req.push_back(r);
            vec_exp.push_back(e);
        end
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_beta(input string name, input regress_pkg::solve_rsp_t exp_rsp,
                              input regress_pkg::solve_rsp_t act_rsp, inout bit ok);
        if (act_rsp.beta !== exp_rsp.beta) begin
            $display("Fail %s beta expected %h %h %h actual %h %h %h", name,
                     exp_rsp.beta[0], exp_rsp.beta[1], exp_rsp.beta[2],
                     act_rsp.beta[0], act_rsp.beta[1], act_rsp.beta[2]);
            ok = 1'b0;
        end
    endtask

    task automatic check_singular(input string name, input regress_pkg::solve_rsp_t exp_rsp,
                                  input regress_pkg::solve_rsp_t act_rsp, inout bit ok);
        if (act_rsp.singular !== exp_rsp.singular) begin
            $display("Fail %s singular expected %b actual %b", name,
                     exp_rsp.singular, act_rsp.singular);
            ok = 1'b0;
        end
    endtask

    task automatic score_response(input regress_pkg::solve_rsp_t exp_rsp, input string name,
                                  input regress_pkg::solve_rsp_t act_rsp);
        bit ok;
        ok = 1'b1;
        check_beta(name, exp_rsp, act_rsp, ok);
        check_singular(name, exp_rsp, act_rsp, ok);
        if (ok) begin
            pass_cnt++;
            $display("Pass %s", name);
        end else begin
            fail_cnt++;
        end
    endtask

    // outputs settle after the rising edge, look at them mid-cycle
    always @(negedge clk) begin
        if (rsp_valid) begin
            recv_cnt++;
            if (exp_q.size() == 0) begin
                $display("response arrived with no problem outstanding");
                misc_err++;
            end else begin
                score_response(exp_q.pop_front(), name_q.pop_front(), rsp);
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic send_problem(input int idx, input string tag);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= vec_req[idx];
        exp_q.push_back(vec_exp[idx]);
        name_q.push_back($sformatf("%s_%0d", tag, idx));
        sent_cnt++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int i;
        i = 0;
        while (recv_cnt < sent_cnt && i < max_cycles) begin
            @(posedge clk);
            i++;
        end
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * 40);  // cycles of the 40 ns clock
        $display("timeout after %0d cycles with %0d responses missing", cycles,
                 sent_cnt - recv_cnt);
        $display("RESULT: FAIL");
        $finish;
    endtask

    initial begin
        int gap;
        req_valid = 1'b0;
        req       = '0;
        void'($urandom(47));
        load_vectors();
        if (num_vec == 0) begin
            $display("vector file missing or holds no problems");
            misc_err++;
        end else begin
            fork
                watchdog(run_cycles(num_vec));
            join_none
            while (rst_n !== 1'b1) @(posedge clk);
            idle_cycles(2);
            // diagonal and identity, each alone in the pipeline
            for (int n = 0; n < 2 && n < num_vec; n++) begin
                send_problem(n, "single");
                idle_cycles(1);
                wait_drain(regress_pkg::SOLVE_LATENCY + 5);
            end
            // whole file with 0..3 idle cycles after each problem
            for (int n = 0; n < num_vec; n++) begin
                send_problem(n, "gap");
                gap = int'($urandom % 4);
                if (gap > 0) begin
                    idle_cycles(gap);
                end
            end
            // one problem per cycle, many in flight
            for (int n = 0; n < num_vec; n++) begin
                send_problem(n, "b2b");
            end
            idle_cycles(1);
            wait_drain(regress_pkg::SOLVE_LATENCY + 10);
            idle_cycles(5);  // stray responses would land here
        end
        if (exp_q.size() != 0) begin
            $display("%0d problems got no response", exp_q.size());
            misc_err += exp_q.size();
        end
        $display("passed %0d failed %0d sent %0d received %0d other %0d assertions %0d",
                 pass_cnt, fail_cnt, sent_cnt, recv_cnt, misc_err,
                 dut0.u_solver.u_assert.fail_cnt);
        if (fail_cnt == 0 && misc_err == 0 && pass_cnt == sent_cnt &&
            dut0.u_solver.u_assert.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== regress_vectors.txt ====
// first word: problem count; per problem, line 1: a00 a01 a02 a10 a11 a12 a20 a21 a22
// line 2: b0 b1 b2, expected beta0 beta1 beta2, expected singular flag (all Q16.16 hex)
0000000a
00020000 00000000 00000000 00000000 00040000 00000000 00000000 00000000 00080000
00060000 00020000 00010000 00030000 00008000 00002000 00000000
00010000 00000000 00000000 00000000 00010000 00000000 00000000 00000000 00010000
00018000 fffe0000 00004000 00018000 fffe0000 00004000 00000000
00000000 00010000 00000000 00020000 00000000 00000000 00000000 00000000 00010000
00030000 00040000 00050000 00020000 00030000 00050000 00000000
00010000 00010000 00010000 00040000 00000000 00020000 00020000 00020000 00000000
00060000 000a0000 00060000 00010000 00020000 00030000 00000000
00020000 00020000 00000000 00010000 00010000 00010000 00000000 00010000 00020000
00000000 00020000 00030000 00010000 ffff0000 00020000 00000000
00000000 00010000 00020000 00000000 00030000 00040000 00000000 00050000 00060000
00010000 00020000 00030000 00000000 00000000 00000000 00000001
00020000 00040000 00060000 00020000 00040000 00060000 00010000 00030000 00050000
00080000 00080000 00090000 00000000 00000000 00000000 00000001
fffc0000 00020000 00000000 00020000 ffff0000 00010000 00000000 00020000 fffe0000
00000000 ffff0000 00040000 00008000 00010000 ffff0000 00000000
00030000 00000000 00000000 00000000 fffd0000 00000000 00000000 00000000 00010000
00010000 00010000 00020000 00005555 ffffaaab 00020000 00000000
00040000 00020000 00020000 00020000 00030000 00010000 00020000 00010000 00030000
00010000 fffc8000 00018000 00010000 fffe0000 00008000 00000000

// ==== files.f ====
regress_pkg.sv
fx_mul.sv
fx_div.sv
gauss_solver3x3.sv
regress_top.sv
regress_assert.sv
tb_clkgen.sv
tb_regress.sv

// ==== run.sh ====
#!/bin/sh
# build the solver testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_regress \
        -f files.f -o sim_regress; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_regress +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
